/* Bender.yml */
package:
  name: matrix_tanh

sources:
  - files:
      - common/ntm_tanh_pkg.sv
      - tanh_lane/tanh_lane.sv
      - verilog/tanh_sequencer.sv
      - verilog/tanh_dispatcher.sv
      - verilog/tanh_collector.sv
      - verilog/matrix_tanh_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_matrix_tanh.sv

/* all.f */
+incdir+test
common/ntm_tanh_pkg.sv
tanh_lane/tanh_lane.sv
verilog/tanh_sequencer.sv
verilog/tanh_dispatcher.sv
verilog/tanh_collector.sv
verilog/matrix_tanh_top.sv
test/tb_matrix_tanh.sv

/* common/ntm_tanh_pkg.sv */
// Q8.8 fixed-point constants, tanh breakpoints and the tagged element struct
`default_nettype none

package ntm_tanh_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Number format
  ////////////////////////////////////////////////////////////////////////////

  // Signed word width
  localparam int data_w = 16;

  // Fraction bits, Q8.8
  localparam int frac_w = 8;

  // Matrix dimension width, 1 to 255
  localparam int size_w = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Piecewise-linear tanh constants
  ////////////////////////////////////////////////////////////////////////////

  // All values are magnitudes, the sign is handled separately in the lane
  // Every constant is a small integer shifted into place

  // 0.5, end of the identity segment and base of the second segment
  localparam logic [data_w-1:0] brk_half = data_w'(1) << (frac_w - 1);

  // 1.25, end of the slope 1/2 segment
  localparam logic [data_w-1:0] brk_mid = data_w'(5) << (frac_w - 2);

  // 2.25, start of saturation
  localparam logic [data_w-1:0] brk_sat = data_w'(9) << (frac_w - 2);

  // 0.875, base of the slope 1/8 segment
  localparam logic [data_w-1:0] val_mid = data_w'(7) << (frac_w - 3);

  // 1.0, saturation level
  localparam logic [data_w-1:0] val_one = data_w'(1) << frac_w;

  ////////////////////////////////////////////////////////////////////////////
  // Element in flight
  ////////////////////////////////////////////////////////////////////////////

  // 18 bits wide, carried from the sequencer to the collector
  typedef struct packed {
    // Signed Q8.8 value
    logic signed [data_w-1:0] data;
    // Last element of a row
    logic                     row_last;
    // Last element of the matrix
    logic                     matrix_last;
  } elem_t;

endpackage

`default_nettype wire

/* tanh_lane/tanh_lane.sv */
// Two-stage pipelined piecewise-linear tanh on one tagged element
`timescale 1ns/1ps
`default_nettype none

module tanh_lane (
  input  wire logic                CLK,
  input  wire logic                RST,

  // Element in
  input  wire ntm_tanh_pkg::elem_t lane_elem,
  input  wire logic                lane_in_valid,

  // Element out two cycles later
  output      ntm_tanh_pkg::elem_t lane_out,
  output      logic                lane_out_valid
);

  // Segment codes
  localparam logic [1:0] seg_lin  = 2'd0;
  localparam logic [1:0] seg_half = 2'd1;
  localparam logic [1:0] seg_8th  = 2'd2;
  localparam logic [1:0] seg_sat  = 2'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 registers sign, magnitude and segment
  ////////////////////////////////////////////////////////////////////////////

  // Unsigned magnitude so that -32768 maps to 0x8000 and saturates
  logic [ntm_tanh_pkg::data_w-1:0] mag;
  logic [1:0]                      seg;

  logic                            s1_valid;
  logic                            s1_neg;
  logic [ntm_tanh_pkg::data_w-1:0] s1_mag;
  logic [1:0]                      s1_seg;
  logic                            s1_row_last;
  logic                            s1_matrix_last;

  always_comb begin
    mag = lane_elem.data[ntm_tanh_pkg::data_w-1] ? -lane_elem.data : lane_elem.data;
    if (mag < ntm_tanh_pkg::brk_half) begin
      seg = seg_lin;
    end else if (mag < ntm_tanh_pkg::brk_mid) begin
      seg = seg_half;
    end else if (mag < ntm_tanh_pkg::brk_sat) begin
      seg = seg_8th;
    end else begin
      seg = seg_sat;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2 adds base and shifted excess and restores the sign
  ////////////////////////////////////////////////////////////////////////////

  logic [ntm_tanh_pkg::data_w-1:0] res_mag;

  always_comb begin
    case (s1_seg)
      seg_lin:  res_mag = s1_mag;
      // 0.5 + (x - 0.5) / 2
      seg_half: res_mag = ntm_tanh_pkg::brk_half + ((s1_mag - ntm_tanh_pkg::brk_half) >> 1);
      // 0.875 + (x - 1.25) / 8
      seg_8th:  res_mag = ntm_tanh_pkg::val_mid + ((s1_mag - ntm_tanh_pkg::brk_mid) >> 3);
      default:  res_mag = ntm_tanh_pkg::val_one;
    endcase
  end

  // Valid pipeline
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid       <= 1'b0;
      lane_out_valid <= 1'b0;
    end else begin
      s1_valid       <= lane_in_valid;
      lane_out_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    // Stage 1
    s1_neg               <= lane_elem.data[ntm_tanh_pkg::data_w-1];
    s1_mag               <= mag;
    s1_seg               <= seg;
    s1_row_last          <= lane_elem.row_last;
    s1_matrix_last       <= lane_elem.matrix_last;
    // Stage 2
    lane_out.data        <= s1_neg ? -$signed(res_mag) : $signed(res_mag);
    lane_out.row_last    <= s1_row_last;
    lane_out.matrix_last <= s1_matrix_last;
  end

  // Results stay within plus or minus 1.0
  a_out_range : assert property (
    @(posedge CLK) disable iff (RST)
    lane_out_valid |-> ($signed(lane_out.data) <= $signed(ntm_tanh_pkg::val_one) &&
      $signed(lane_out.data) >= -$signed(ntm_tanh_pkg::val_one))
  ) else $error("tanh_lane: result above 1.0 in magnitude");

endmodule

`default_nettype wire

/* test/tb_tanh_model.svh */
// Reference piecewise-linear tanh and the expected-output queue of the testbench
`ifndef TB_TANH_MODEL_SVH
`define TB_TANH_MODEL_SVH

// Expected elements, oldest first
ntm_tanh_pkg::elem_t exp_q[$];

// Copy of the queue head for the checkers
ntm_tanh_pkg::elem_t exp_head = '0;
logic                exp_avail = 1'b0;

// Totals the output stream must carry
int exp_elems = 0;
int exp_rows  = 0;
int exp_mats  = 0;

// Odd-symmetric tanh in Q8.8, three slopes then 1.0
function automatic logic signed [ntm_tanh_pkg::data_w-1:0] tanh_ref(
  input logic signed [ntm_tanh_pkg::data_w-1:0] x
);
  int mag;
  int res;
  // Full int, so -32768 has a magnitude too
  mag = (x < 0) ? -int'(x) : int'(x);
  if (mag < int'(ntm_tanh_pkg::brk_half)) begin
    res = mag;
  end else if (mag < int'(ntm_tanh_pkg::brk_mid)) begin
    // Slope 1/2 above 0.5
    res = int'(ntm_tanh_pkg::brk_half) + (mag - int'(ntm_tanh_pkg::brk_half)) / 2;
  end else if (mag < int'(ntm_tanh_pkg::brk_sat)) begin
    // Slope 1/8 above 1.25
    res = int'(ntm_tanh_pkg::val_mid) + (mag - int'(ntm_tanh_pkg::brk_mid)) / 8;
  end else begin
    res = int'(ntm_tanh_pkg::val_one);
  end
  return (x < 0) ? ntm_tanh_pkg::data_w'(-res) : ntm_tanh_pkg::data_w'(res);
endfunction

// Mirror of the head, read by the assertions
task automatic refresh_head();
  exp_avail = (exp_q.size() > 0);
  exp_head  = exp_avail ? exp_q[0] : '0;
endtask

// One accepted input becomes one expected output
task automatic expect_elem(input logic signed [ntm_tanh_pkg::data_w-1:0] x,
                           input logic row_last, input logic mat_last);
  ntm_tanh_pkg::elem_t e;
  e.data        = tanh_ref(x);
  e.row_last    = row_last;
  e.matrix_last = mat_last;
  exp_q.push_back(e);
  exp_elems++;
  exp_rows += row_last;
  exp_mats += mat_last;
  refresh_head();
endtask

// Output seen, next element moves up
task automatic drop_head();
  void'(exp_q.pop_front());
  refresh_head();
endtask

`endif

/* test/tb_matrix_tanh.sv */
// Matrix tanh testbench: clock, reset, stimulus, checking assertions, timeout and report
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_tanh;

  localparam int num_lanes  = 4;
  // About 120 elements, each at most 4 cycles apart, plus plenty of margin
  localparam int max_cycles = 4000;

  logic                                   CLK;
  logic                                   RST;
  logic                                   START;
  logic        [ntm_tanh_pkg::size_w-1:0] size_i;
  logic        [ntm_tanh_pkg::size_w-1:0] size_j;
  logic signed [ntm_tanh_pkg::data_w-1:0] data_in;
  logic                                   data_in_i_enable;
  logic                                   data_in_j_enable;
  logic                                   busy;
  logic signed [ntm_tanh_pkg::data_w-1:0] data_out;
  logic                                   data_out_i_enable;
  logic                                   data_out_j_enable;
  logic                                   ready;

  // Stimulus values waiting to be sent
  logic signed [ntm_tanh_pkg::data_w-1:0] vals[$];

  integer seed      = 43428;
  int     cycles    = 0;
  int     data_errs = 0;
  int     tag_errs  = 0;
  int     misc_errs = 0;
  // Output strobes seen
  int     n_j       = 0;
  int     n_i       = 0;
  int     n_ready   = 0;

  `include "tb_tanh_model.svh"

  matrix_tanh_top #(
    .NUM_LANES(num_lanes)
  ) matrix_tanh_top_inst (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .size_i           (size_i),
    .size_j           (size_j),
    .busy             (busy),
    .data_in          (data_in),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .data_out         (data_out),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .ready            (ready)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Hard stop
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: outputs still missing after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Retire one expected element per output strobe
  always @(posedge CLK) begin
    if (!RST && data_out_j_enable) begin
      n_j++;
      n_i += data_out_i_enable;
      n_ready += ready;
      if (exp_q.size() > 0) begin
        drop_head();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////////////////////

  strobe_expected : assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |-> exp_avail)
    else begin
      misc_errs++;
      $display("Output strobe at cycle %0d with no element outstanding", cycles);
    end

  data_match : assert property (@(posedge CLK) disable iff (RST)
    (data_out_j_enable && exp_avail) |-> data_out == exp_head.data)
    else begin
      data_errs++;
      $display("Error: data_out expected %h got %h",
               $sampled(exp_head.data), $sampled(data_out));
    end

  row_end_match : assert property (@(posedge CLK) disable iff (RST)
    (data_out_j_enable && exp_avail) |-> data_out_i_enable == exp_head.row_last)
    else begin
      tag_errs++;
      $display("Error: data_out_i_enable expected %h got %h",
               $sampled(exp_head.row_last), $sampled(data_out_i_enable));
    end

  ready_match : assert property (@(posedge CLK) disable iff (RST)
    (data_out_j_enable && exp_avail) |-> ready == exp_head.matrix_last)
    else begin
      tag_errs++;
      $display("Error: ready expected %h got %h",
               $sampled(exp_head.matrix_last), $sampled(ready));
    end

  // Row end and ready only ride on an element
  tags_need_strobe : assert property (@(posedge CLK) disable iff (RST)
    !data_out_j_enable |-> (!data_out_i_enable && !ready))
    else begin
      misc_errs++;
      $display("Row-end or ready strobe without a data strobe at cycle %0d", cycles);
    end

  reset_quiet : assert property (@(posedge CLK)
    (RST || $past(RST)) |-> !(busy || data_out_j_enable || data_out_i_enable || ready))
    else begin
      misc_errs++;
      $display("busy or an output strobe was high in or right after reset");
    end

  start_busy : assert property (@(posedge CLK) disable iff (RST)
    (START && !busy) |=> busy)
    else begin
      misc_errs++;
      $display("busy did not rise after START at cycle %0d", cycles);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_cycle();
    @(posedge CLK);
    START            <= 1'b0;
    data_in_i_enable <= 1'b0;
    data_in_j_enable <= 1'b0;
  endtask

  // i_enable opens a row, j_enable carries the rest
  task automatic strobe(input logic signed [ntm_tanh_pkg::data_w-1:0] value,
                        input logic row_start);
    @(posedge CLK);
    START            <= 1'b0;
    data_in          <= value;
    data_in_i_enable <= row_start;
    data_in_j_enable <= !row_start;
  endtask

  // START with odd sizes while a matrix is running
  task automatic stray_start();
    @(posedge CLK);
    START            <= 1'b1;
    size_i           <= ntm_tanh_pkg::size_w'(1);
    size_j           <= ntm_tanh_pkg::size_w'(1);
    data_in_i_enable <= 1'b0;
    data_in_j_enable <= 1'b0;
  endtask

  // Next START goes out on the first edge with busy low
  task automatic start_matrix(input int rows, input int cols);
    do begin
      idle_cycle();
    end while (busy);
    START  <= 1'b1;
    size_i <= ntm_tanh_pkg::size_w'(rows);
    size_j <= ntm_tanh_pkg::size_w'(cols);
  endtask

  task automatic send_matrix(input int rows, input int cols, input bit gaps, input bit faults);
    logic signed [ntm_tanh_pkg::data_w-1:0] v;
    start_matrix(rows, cols);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        v = vals.pop_front();
        if (gaps) begin
          repeat ($unsigned($random(seed)) % 4) idle_cycle();
        end
        // Wrong kinds for the position, all dropped
        if (faults && c == 0) begin
          strobe(16'sh7f00, 1'b0);
          stray_start();
        end
        if (faults && c == 1) begin
          strobe(-16'sh7f00, 1'b1);
        end
        strobe(v, c == 0);
        expect_elem(v, c == cols - 1, (r == rows - 1) && (c == cols - 1));
      end
    end
  endtask

  // Narrow range covers every segment, wide range mostly saturates
  task automatic fill_random(input int n, input bit wide);
    repeat (n) begin
      if (wide) begin
        vals.push_back(ntm_tanh_pkg::data_w'($random(seed)));
      end else begin
        vals.push_back(ntm_tanh_pkg::data_w'($random(seed) % 800));
      end
    end
  endtask

  task automatic push_both_signs(input int v);
    vals.push_back(ntm_tanh_pkg::data_w'(v));
    vals.push_back(ntm_tanh_pkg::data_w'(-v));
  endtask

  // Breakpoints, one LSB below them, small and huge magnitudes, 24 values
  task automatic fill_directed();
    vals.push_back(16'sd0);
    vals.push_back(-16'sd32768);
    push_both_signs(int'(ntm_tanh_pkg::brk_half));
    push_both_signs(int'(ntm_tanh_pkg::brk_half) - 1);
    push_both_signs(int'(ntm_tanh_pkg::brk_mid));
    push_both_signs(int'(ntm_tanh_pkg::brk_mid) - 1);
    push_both_signs(int'(ntm_tanh_pkg::brk_sat));
    push_both_signs(int'(ntm_tanh_pkg::brk_sat) - 1);
    push_both_signs(1);
    push_both_signs(200);
    push_both_signs(400);
    push_both_signs(1000);
    push_both_signs(32767);
  endtask

  initial begin
    RST              = 1'b1;
    START            = 1'b0;
    size_i           = '0;
    size_j           = '0;
    data_in          = '0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;

    // Random values, 3 by 4
    fill_random(12, 1'b0);
    send_matrix(3, 4, 1'b0, 1'b0);
    // Segments and sign
    fill_directed();
    send_matrix(4, 6, 1'b0, 1'b0);
    // Degenerate shapes
    fill_random(11, 1'b1);
    send_matrix(1, 1, 1'b0, 1'b0);
    send_matrix(1, 5, 1'b0, 1'b0);
    send_matrix(5, 1, 1'b0, 1'b0);
    // Back to back, then random gaps
    fill_random(64, 1'b0);
    send_matrix(4, 8, 1'b0, 1'b0);
    send_matrix(4, 8, 1'b1, 1'b0);

    // Strobes while idle, then faults inside a matrix
    do begin
      idle_cycle();
    end while (busy);
    strobe(16'sh0100, 1'b1);
    strobe(16'sh0200, 1'b0);
    fill_random(9, 1'b0);
    send_matrix(3, 3, 1'b1, 1'b1);
    strobe(16'sh0300, 1'b1);
    strobe(16'sh0400, 1'b0);

    // Drain, then leave room for any extra strobe
    while (exp_q.size() > 0) begin
      idle_cycle();
    end
    repeat (8) idle_cycle();

    elem_count : assert (n_j == exp_elems)
      else begin
        misc_errs++;
        $display("Error: data_out_j_enable count expected %h got %h", exp_elems, n_j);
      end
    row_count : assert (n_i == exp_rows)
      else begin
        misc_errs++;
        $display("Error: data_out_i_enable count expected %h got %h", exp_rows, n_i);
      end
    ready_count : assert (n_ready == exp_mats)
      else begin
        misc_errs++;
        $display("Error: ready count expected %h got %h", exp_mats, n_ready);
      end

    $display("Errors: data %0d, tags %0d, other %0d over %0d elements",
             data_errs, tag_errs, misc_errs, n_j);
    if (data_errs + tag_errs + misc_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/matrix_tanh_top.sv */
// Element-wise tanh top level: sequencer, dispatcher, lane array, collector
`timescale 1ns/1ps
`default_nettype none

module matrix_tanh_top #(
  parameter int NUM_LANES = 4
) (
  // Clock and reset
  input  wire logic                                   CLK,
  input  wire logic                                   RST,

  // Matrix control
  input  wire logic                                   START,
  input  wire logic        [ntm_tanh_pkg::size_w-1:0] size_i,
  input  wire logic        [ntm_tanh_pkg::size_w-1:0] size_j,
  output      logic                                   busy,

  // Input stream
  input  wire logic signed [ntm_tanh_pkg::data_w-1:0] data_in,
  input  wire logic                                   data_in_i_enable,
  input  wire logic                                   data_in_j_enable,

  // Output stream
  output      logic signed [ntm_tanh_pkg::data_w-1:0] data_out,
  output      logic                                   data_out_i_enable,
  output      logic                                   data_out_j_enable,
  output      logic                                   ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal streams
  ////////////////////////////////////////////////////////////////////////////

  // Sequencer to dispatcher
  ntm_tanh_pkg::elem_t                 seq_elem;
  logic                                seq_valid;

  // Dispatcher to lanes
  ntm_tanh_pkg::elem_t [NUM_LANES-1:0] lane_elem;
  logic                [NUM_LANES-1:0] lane_in_valid;

  // Lanes to collector
  ntm_tanh_pkg::elem_t [NUM_LANES-1:0] lane_out;
  logic                [NUM_LANES-1:0] lane_out_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  // Strobe decode, counting and tagging
  tanh_sequencer tanh_sequencer_inst (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .size_i          (size_i),
    .size_j          (size_j),
    .data_in         (data_in),
    .data_in_i_enable(data_in_i_enable),
    .data_in_j_enable(data_in_j_enable),
    .busy            (busy),
    .seq_elem        (seq_elem),
    .seq_valid       (seq_valid)
  );

  // Round-robin fan-out
  tanh_dispatcher #(
    .NUM_LANES(NUM_LANES)
  ) tanh_dispatcher_inst (
    .CLK          (CLK),
    .RST          (RST),
    .seq_elem     (seq_elem),
    .seq_valid    (seq_valid),
    .lane_elem    (lane_elem),
    .lane_in_valid(lane_in_valid)
  );

  // One pipelined tanh per lane
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    tanh_lane tanh_lane_inst (
      .CLK           (CLK),
      .RST           (RST),
      .lane_elem     (lane_elem[k]),
      .lane_in_valid (lane_in_valid[k]),
      .lane_out      (lane_out[k]),
      .lane_out_valid(lane_out_valid[k])
    );
  end

  // Merge and output strobes
  tanh_collector #(
    .NUM_LANES(NUM_LANES)
  ) tanh_collector_inst (
    .CLK              (CLK),
    .RST              (RST),
    .lane_out         (lane_out),
    .lane_out_valid   (lane_out_valid),
    .data_out         (data_out),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .ready            (ready)
  );

endmodule

`default_nettype wire

/* verilog/tanh_collector.sv */
// Merges lane results into one stream and regenerates the output strobes
`timescale 1ns/1ps
`default_nettype none

module tanh_collector #(
  parameter int NUM_LANES = 4
) (
  input  wire logic                                   CLK,
  input  wire logic                                   RST,

  // From the lanes
  input  wire ntm_tanh_pkg::elem_t [NUM_LANES-1:0]    lane_out,
  input  wire logic                [NUM_LANES-1:0]    lane_out_valid,

  // Output stream
  output      logic signed [ntm_tanh_pkg::data_w-1:0] data_out,
  output      logic                                   data_out_i_enable,
  output      logic                                   data_out_j_enable,
  output      logic                                   ready
);

  // Selected lane result
  ntm_tanh_pkg::elem_t sel;
  logic                any_valid;

  // At most one lane is valid, so a plain scan picks it
  always_comb begin
    sel       = '0;
    any_valid = 1'b0;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (lane_out_valid[k]) begin
        sel       = lane_out[k];
        any_valid = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out          <= '0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      ready             <= 1'b0;
    end else begin
      // Strobe per element, row end and matrix end from the tags
      data_out_j_enable <= any_valid;
      data_out_i_enable <= any_valid && sel.row_last;
      ready             <= any_valid && sel.matrix_last;
      // Data holds between elements
      if (any_valid) begin
        data_out <= sel.data;
      end
    end
  end

  // Equal lane latency keeps round-robin results one per cycle
  a_single_lane : assert property (
    @(posedge CLK) disable iff (RST) $onehot0(lane_out_valid)
  ) else $error("tanh_collector: more than one lane valid");

endmodule

`default_nettype wire

/* verilog/tanh_dispatcher.sv */
// Round-robin distribution of tagged elements to the tanh lanes
`timescale 1ns/1ps
`default_nettype none

module tanh_dispatcher #(
  parameter int NUM_LANES = 4
) (
  input  wire logic                                CLK,
  input  wire logic                                RST,

  // From the sequencer
  input  wire ntm_tanh_pkg::elem_t                 seq_elem,
  input  wire logic                                seq_valid,

  // One register per lane
  output      ntm_tanh_pkg::elem_t [NUM_LANES-1:0] lane_elem,
  output      logic                [NUM_LANES-1:0] lane_in_valid
);

  // Pointer wide enough for a single lane too
  localparam int ptr_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // Lane that takes the next element
  logic [ptr_w-1:0] ptr;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ptr           <= '0;
      lane_in_valid <= '0;
    end else begin
      lane_in_valid <= '0;
      if (seq_valid) begin
        lane_in_valid[ptr] <= 1'b1;
        // Wrap after the last lane
        if (ptr == ptr_w'(NUM_LANES - 1)) begin
          ptr <= '0;
        end else begin
          ptr <= ptr + 1'b1;
        end
      end
    end
  end

  // Payload only moves into the selected lane
  always_ff @(posedge CLK) begin
    if (seq_valid) begin
      lane_elem[ptr] <= seq_elem;
    end
  end

  // At most one lane strobe per cycle
  a_one_lane : assert property (
    @(posedge CLK) disable iff (RST) $onehot0(lane_in_valid)
  ) else $error("tanh_dispatcher: lane strobes not one-hot");

endmodule

`default_nettype wire

/* verilog/tanh_sequencer.sv */
// Matrix control FSM: input strobe decode, row and column counters, element tagging
`timescale 1ns/1ps
`default_nettype none

module tanh_sequencer (
  input  wire logic                                   CLK,
  input  wire logic                                   RST,

  // Matrix control
  input  wire logic                                   START,
  input  wire logic        [ntm_tanh_pkg::size_w-1:0] size_i,
  input  wire logic        [ntm_tanh_pkg::size_w-1:0] size_j,

  // Input stream
  input  wire logic signed [ntm_tanh_pkg::data_w-1:0] data_in,
  input  wire logic                                   data_in_i_enable,
  input  wire logic                                   data_in_j_enable,

  // Status and tagged stream
  output      logic                                   busy,
  output      ntm_tanh_pkg::elem_t                    seq_elem,
  output      logic                                   seq_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // State and counters
  ////////////////////////////////////////////////////////////////////////////

  // Idle, waiting for a row start, inside a row
  typedef enum logic [1:0] {
    st_idle,
    st_row_start,
    st_in_row
  } state_t;

  state_t                          state;

  // Sizes held for the whole matrix
  logic [ntm_tanh_pkg::size_w-1:0] size_i_q;
  logic [ntm_tanh_pkg::size_w-1:0] size_j_q;

  // Position of the next expected element
  logic [ntm_tanh_pkg::size_w-1:0] row_cnt;
  logic [ntm_tanh_pkg::size_w-1:0] col_cnt;

  logic                            accept;
  logic                            col_last;
  logic                            mat_last;

  // Only the enable matching the position counts
  assign accept = ((state == st_row_start) && data_in_i_enable) ||
                  ((state == st_in_row) && data_in_j_enable);

  // Position flags of the element being accepted
  assign col_last = (col_cnt == size_j_q - 1'b1);
  assign mat_last = col_last && (row_cnt == size_i_q - 1'b1);

  assign busy = (state != st_idle);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= st_idle;
      size_i_q  <= '0;
      size_j_q  <= '0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      seq_valid <= 1'b0;
    end else begin
      seq_valid <= accept;
      case (state)
        st_idle: begin
          // START outside idle is dropped
          if (START) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            row_cnt  <= '0;
            col_cnt  <= '0;
            state    <= st_row_start;
          end
        end
        st_row_start, st_in_row: begin
          if (accept) begin
            if (mat_last) begin
              state <= st_idle;
            end else if (col_last) begin
              // Next row starts with i_enable
              row_cnt <= row_cnt + 1'b1;
              col_cnt <= '0;
              state   <= st_row_start;
            end else begin
              col_cnt <= col_cnt + 1'b1;
              state   <= st_in_row;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Tagged payload
  always_ff @(posedge CLK) begin
    if (accept) begin
      seq_elem.data        <= data_in;
      seq_elem.row_last    <= col_last;
      seq_elem.matrix_last <= mat_last;
    end
  end

  // Source never strobes both kinds in one cycle
  a_enables_exclusive : assert property (
    @(posedge CLK) disable iff (RST) !(data_in_i_enable && data_in_j_enable)
  ) else $error("tanh_sequencer: i_enable and j_enable high together");

endmodule

`default_nettype wire
